//--- zx81_mem_pkg.sv
`default_nettype none

package zx81_mem_pkg;

	// ========================================================================
	// Machine configuration
	// ========================================================================
	typedef enum logic {
		MACHINE_ZX81 = 1'b0,
		MACHINE_ZX80 = 1'b1
	} machine_t;

	typedef enum logic [1:0] {
		RAM_1K  = 2'd0,
		RAM_16K = 2'd1,
		RAM_32K = 2'd2,
		RAM_48K = 2'd3
	} ram_size_t;

	// .o files are ZX80, .p files are ZX81
	typedef enum logic {
		TAPE_O = 1'b0,
		TAPE_P = 1'b1
	} tape_format_t;

	typedef enum logic [1:0] {
		LOAD_IDLE = 2'd0,
		LOAD_COPY = 2'd1,
		LOAD_WAIT = 2'd2
	} loader_state_t;

	// Bus widths
	localparam int CPU_ADDR_W  = 16;
	localparam int RAM_ADDR_W  = 16;
	localparam int TAPE_ADDR_W = 14;
	localparam int DATA_W      = 8;

	// ========================================================================
	// ROM load routine trap
	// ========================================================================
	localparam logic [CPU_ADDR_W-1:0] TRAP_ENTRY_ZX81 = 16'h0347;
	localparam logic [CPU_ADDR_W-1:0] TRAP_ENTRY_ZX80 = 16'h0207;
	localparam logic [CPU_ADDR_W-1:0] TRAP_END_ZX81   = 16'h03C3;
	localparam logic [CPU_ADDR_W-1:0] TRAP_END_ZX80   = 16'h024D;

	// .p data skips the system variables below 4009h
	localparam logic [RAM_ADDR_W-1:0] LOAD_BASE_P = 16'h4009;
	localparam logic [RAM_ADDR_W-1:0] LOAD_BASE_O = 16'h4000;

	localparam int PATCH_LEN = 7;

	// Relative offset of the JR NC back onto the NOP/SCF byte
	localparam logic [DATA_W-1:0] JR_LOOP_OFS = 8'hFD;
	// Return into the ROM after the load, 0207h or 0203h
	localparam logic [DATA_W-1:0] JP_LO_ZX81  = 8'h07;
	localparam logic [DATA_W-1:0] JP_LO_ZX80  = 8'h03;
	localparam logic [DATA_W-1:0] JP_HI       = 8'h02;

	typedef enum logic [7:0] {
		OP_NOP   = 8'h00,
		OP_JR_NC = 8'h30,
		OP_SCF   = 8'h37,
		OP_XOR_A = 8'hAF,
		OP_JP    = 8'hC3
	} z80_op_t;

endpackage

`default_nettype wire

//--- tape_buffer.sv
`default_nettype none

module tape_buffer #(
	parameter int TAPE_DEPTH = 16384
) (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 dl_active,
	input  logic                                 dl_wr,
	input  logic [zx81_mem_pkg::TAPE_ADDR_W-1:0] dl_addr,
	input  logic [zx81_mem_pkg::DATA_W-1:0]      dl_data,
	input  logic [7:0]                           dl_index,
	input  logic [zx81_mem_pkg::TAPE_ADDR_W-1:0] tb_raddr,
	output logic [zx81_mem_pkg::DATA_W-1:0]      tb_rdata,
	output logic [zx81_mem_pkg::TAPE_ADDR_W:0]   tape_len,
	output zx81_mem_pkg::tape_format_t           tape_format,
	output logic                                 tape_ready
);
	import zx81_mem_pkg::*;

	logic [DATA_W-1:0]      tape_mem [0:TAPE_DEPTH-1];
	logic [TAPE_ADDR_W-1:0] last_addr;
	logic                   dl_active_q;
	logic                   tape_sel;
	logic                   dl_end;

	// Tape slots: index bits 4..0 set, bits 7 and 5 clear
	assign tape_sel = (|dl_index[4:0]) & ~dl_index[7] & ~dl_index[5];
	assign dl_end   = dl_active_q & ~dl_active & tape_sel;

	// Host side write port
	always_ff @(posedge clk_sys) begin
		if (tape_sel && dl_wr) begin
			tape_mem[dl_addr] <= dl_data;
			last_addr         <= dl_addr;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_active_q <= 1'b0;
			tape_len    <= '0;
		end else begin
			dl_active_q <= dl_active;
			if (dl_end)
				tape_len <= {1'b0, last_addr} + 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (dl_end)
			tape_format <= tape_format_t'(dl_index[6]);
	end

	// Loader read port, one cycle latency
	always_ff @(posedge clk_sys) begin
		tb_rdata <= tape_mem[tb_raddr];
	end

	assign tape_ready = |tape_len;

endmodule

`default_nettype wire

//--- tape_loader.sv
`default_nettype none

module tape_loader #(
	parameter int TAPE_DEPTH = 16384
) (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  zx81_mem_pkg::machine_t               model,
	input  logic [zx81_mem_pkg::CPU_ADDR_W-1:0]  cpu_addr,
	input  logic                                 cpu_rd,
	input  logic                                 cpu_m1,
	input  logic [zx81_mem_pkg::TAPE_ADDR_W:0]   tape_len,
	input  zx81_mem_pkg::tape_format_t           tape_format,
	input  logic [zx81_mem_pkg::DATA_W-1:0]      tb_rdata,
	output logic [zx81_mem_pkg::TAPE_ADDR_W-1:0] tb_raddr,
	output logic                                 ld_req,
	output logic [zx81_mem_pkg::RAM_ADDR_W-1:0]  ld_addr,
	output logic [zx81_mem_pkg::DATA_W-1:0]      ld_data,
	output logic                                 loading,
	output logic                                 patch_hit,
	output logic [zx81_mem_pkg::DATA_W-1:0]      patch_data
);
	import zx81_mem_pkg::*;

	loader_state_t          state;
	logic [TAPE_ADDR_W:0]   rd_idx;
	logic [TAPE_ADDR_W-1:0] wr_idx;
	logic                   wr_pending;
	logic [CPU_ADDR_W-1:0]  trap_entry;
	logic [CPU_ADDR_W-1:0]  trap_end;
	logic [RAM_ADDR_W-1:0]  load_base;
	logic [CPU_ADDR_W-1:0]  patch_ofs;
	logic                   fetch;
	logic                   start;
	logic                   exit_fetch;
	logic                   issue;

	assign trap_entry = (model == MACHINE_ZX81) ? TRAP_ENTRY_ZX81 : TRAP_ENTRY_ZX80;
	assign trap_end   = (model == MACHINE_ZX81) ? TRAP_END_ZX81 : TRAP_END_ZX80;
	assign load_base  = (tape_format == TAPE_P) ? LOAD_BASE_P : LOAD_BASE_O;

	assign fetch      = cpu_rd & cpu_m1;
	assign start      = (state == LOAD_IDLE) & fetch & (cpu_addr == trap_entry);
	assign exit_fetch = fetch & ((cpu_addr >= trap_end) | (cpu_addr < trap_entry));

	// Buffer read for the next byte goes out while the previous one is written
	assign issue = (state == LOAD_COPY) & (rd_idx < tape_len) & (rd_idx < TAPE_DEPTH);

	// ========================================================================
	// Loader FSM
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= LOAD_IDLE;
			wr_pending <= 1'b0;
		end else begin
			wr_pending <= issue;
			case (state)
				LOAD_IDLE: begin
					if (start)
						state <= LOAD_COPY;
				end
				LOAD_COPY: begin
					if (exit_fetch)
						state <= LOAD_IDLE;
					else if (!issue && !wr_pending)
						state <= LOAD_WAIT;
				end
				LOAD_WAIT: begin
					if (exit_fetch)
						state <= LOAD_IDLE;
				end
				default: state <= LOAD_IDLE;
			endcase
		end
	end

	// Tape and RAM byte counters
	always_ff @(posedge clk_sys) begin
		if (start) begin
			rd_idx <= '0;
			wr_idx <= '0;
		end else begin
			if (issue)
				rd_idx <= rd_idx + 1'b1;
			if (wr_pending)
				wr_idx <= wr_idx + 1'b1;
		end
	end

	assign tb_raddr = rd_idx[TAPE_ADDR_W-1:0];
	assign loading  = (state != LOAD_IDLE);

	// An in-flight byte after an aborted copy is dropped
	assign ld_req  = wr_pending & loading;
	assign ld_addr = load_base + RAM_ADDR_W'(wr_idx);
	assign ld_data = tb_rdata;

	// ========================================================================
	// Patch program
	// ========================================================================
	// The trap fetch itself already sees the patch
	assign patch_ofs = cpu_addr - trap_entry;
	assign patch_hit = (loading | start) & (patch_ofs < PATCH_LEN);

	always_comb begin
		case (patch_ofs[2:0])
			3'd0:    patch_data = OP_XOR_A;
			3'd1:    patch_data = (state == LOAD_WAIT) ? OP_SCF : OP_NOP;
			3'd2:    patch_data = OP_JR_NC;
			3'd3:    patch_data = JR_LOOP_OFS;
			3'd4:    patch_data = OP_JP;
			3'd5:    patch_data = (model == MACHINE_ZX81) ? JP_LO_ZX81 : JP_LO_ZX80;
			default: patch_data = JP_HI;
		endcase
	end

endmodule

`default_nettype wire

//--- ram_map.sv
`default_nettype none

module ram_map (
	input  zx81_mem_pkg::ram_size_t             ram_size,
	input  logic [zx81_mem_pkg::CPU_ADDR_W-1:0] cpu_addr,
	input  logic                                cpu_m1,
	output logic [zx81_mem_pkg::RAM_ADDR_W-1:0] map_addr,
	output logic                                map_hit
);
	import zx81_mem_pkg::*;

	logic [1:0]  bank;
	logic [13:0] ofs;
	logic        big_ram;

	assign bank    = cpu_addr[CPU_ADDR_W-1 -: 2];
	assign ofs     = cpu_addr[13:0];
	assign big_ram = (ram_size == RAM_32K) | (ram_size == RAM_48K);

	// 4000h and C000h windows always, 8000h only with 32K or 48K fitted
	assign map_hit = cpu_addr[14] | (big_ram & (bank == 2'b10));

	always_comb begin
		case (ram_size)
			RAM_1K: begin
				map_addr = {6'b010000, ofs[9:0]};
			end
			RAM_16K: begin
				map_addr = {2'b01, ofs};
			end
			RAM_32K: begin
				// C000h mirrors the main 16K
				if (bank == 2'b10)
					map_addr = {2'b10, ofs};
				else
					map_addr = {2'b01, ofs};
			end
			RAM_48K: begin
				// Top bank for data, main 16K mirror for M1
				case (bank)
					2'b10:   map_addr = {2'b10, ofs};
					2'b11:   map_addr = cpu_m1 ? {2'b01, ofs} : {2'b11, ofs};
					default: map_addr = {2'b01, ofs};
				endcase
			end
			default: begin
				map_addr = {2'b01, ofs};
			end
		endcase
	end

endmodule

`default_nettype wire

//--- ram_arbiter.sv
`default_nettype none

module ram_arbiter (
	input  logic                                clk_sys,
	input  logic                                reset,
	input  logic                                loading,
	input  logic                                ld_req,
	input  logic [zx81_mem_pkg::RAM_ADDR_W-1:0] ld_addr,
	input  logic [zx81_mem_pkg::DATA_W-1:0]     ld_data,
	input  logic [zx81_mem_pkg::RAM_ADDR_W-1:0] map_addr,
	input  logic                                map_hit,
	input  logic                                cpu_rd,
	input  logic                                cpu_wr,
	input  logic [zx81_mem_pkg::DATA_W-1:0]     cpu_wdata,
	input  logic                                patch_hit,
	input  logic [zx81_mem_pkg::DATA_W-1:0]     patch_data,
	input  logic [zx81_mem_pkg::DATA_W-1:0]     mem_rdata,
	output logic [zx81_mem_pkg::RAM_ADDR_W-1:0] mem_addr,
	output logic                                mem_we,
	output logic [zx81_mem_pkg::DATA_W-1:0]     mem_wdata,
	output logic [zx81_mem_pkg::DATA_W-1:0]     cpu_rdata,
	output logic                                cpu_rvalid
);
	import zx81_mem_pkg::*;

	typedef enum logic [1:0] {
		SRC_FF    = 2'd0,
		SRC_RAM   = 2'd1,
		SRC_PATCH = 2'd2
	} rd_src_t;

	rd_src_t           rd_src;
	logic [DATA_W-1:0] patch_q;
	logic              cpu_ok;
	logic              cpu_we;

	// Loader always wins, CPU is locked out for the whole load
	assign cpu_ok = map_hit & ~loading & ~ld_req;
	assign cpu_we = cpu_wr & cpu_ok;

	assign mem_addr  = ld_req ? ld_addr : map_addr;
	assign mem_wdata = ld_req ? ld_data : cpu_wdata;
	assign mem_we    = ld_req | cpu_we;

	always_ff @(posedge clk_sys) begin
		if (reset)
			cpu_rvalid <= 1'b0;
		else
			cpu_rvalid <= cpu_rd;
	end

	// Remember where the reply comes from, RAM data arrives next cycle
	always_ff @(posedge clk_sys) begin
		if (cpu_rd) begin
			patch_q <= patch_data;
			if (patch_hit)
				rd_src <= SRC_PATCH;
			else if (cpu_ok)
				rd_src <= SRC_RAM;
			else
				rd_src <= SRC_FF;
		end
	end

	always_comb begin
		case (rd_src)
			SRC_RAM:   cpu_rdata = mem_rdata;
			SRC_PATCH: cpu_rdata = patch_q;
			default:   cpu_rdata = 8'hFF;
		endcase
	end

endmodule

`default_nettype wire

//--- main_ram.sv
`default_nettype none

module main_ram (
	input  logic                                clk_sys,
	input  logic [zx81_mem_pkg::RAM_ADDR_W-1:0] mem_addr,
	input  logic                                mem_we,
	input  logic [zx81_mem_pkg::DATA_W-1:0]     mem_wdata,
	output logic [zx81_mem_pkg::DATA_W-1:0]     mem_rdata
);
	import zx81_mem_pkg::*;

	logic [DATA_W-1:0] mem [0:(2**RAM_ADDR_W)-1];

	// Single port, read returns the old contents on a write
	always_ff @(posedge clk_sys) begin
		if (mem_we)
			mem[mem_addr] <= mem_wdata;
		mem_rdata <= mem[mem_addr];
	end

endmodule

`default_nettype wire

//--- zx81_mem_top.sv
`default_nettype none

module zx81_mem_top #(
	parameter int TAPE_DEPTH = 16384
) (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  zx81_mem_pkg::machine_t               model,
	input  zx81_mem_pkg::ram_size_t              ram_size,
	input  logic                                 dl_active,
	input  logic                                 dl_wr,
	input  logic [zx81_mem_pkg::TAPE_ADDR_W-1:0] dl_addr,
	input  logic [zx81_mem_pkg::DATA_W-1:0]      dl_data,
	input  logic [7:0]                           dl_index,
	input  logic [zx81_mem_pkg::CPU_ADDR_W-1:0]  cpu_addr,
	input  logic [zx81_mem_pkg::DATA_W-1:0]      cpu_wdata,
	input  logic                                 cpu_rd,
	input  logic                                 cpu_wr,
	input  logic                                 cpu_m1,
	output logic [zx81_mem_pkg::DATA_W-1:0]      cpu_rdata,
	output logic                                 cpu_rvalid,
	output logic                                 loading,
	output logic                                 tape_ready
);
	import zx81_mem_pkg::*;

	machine_t               model_q;
	ram_size_t              ram_size_q;
	logic [TAPE_ADDR_W-1:0] tb_raddr;
	logic [DATA_W-1:0]      tb_rdata;
	logic [TAPE_ADDR_W:0]   tape_len;
	tape_format_t           tape_format;
	logic                   ld_req;
	logic [RAM_ADDR_W-1:0]  ld_addr;
	logic [DATA_W-1:0]      ld_data;
	logic                   patch_hit;
	logic [DATA_W-1:0]      patch_data;
	logic [RAM_ADDR_W-1:0]  map_addr;
	logic                   map_hit;
	logic [RAM_ADDR_W-1:0]  mem_addr;
	logic                   mem_we;
	logic [DATA_W-1:0]      mem_wdata;
	logic [DATA_W-1:0]      mem_rdata;

	// Machine config follows the inputs only while in reset
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_q    <= model;
			ram_size_q <= ram_size;
		end
	end

	// ========================================================================
	// Tape path
	// ========================================================================
	tape_buffer #(.TAPE_DEPTH(TAPE_DEPTH)) u_tape_buffer (
		.clk_sys, .reset,
		.dl_active, .dl_wr, .dl_addr, .dl_data, .dl_index,
		.tb_raddr, .tb_rdata,
		.tape_len, .tape_format, .tape_ready
	);

	tape_loader #(.TAPE_DEPTH(TAPE_DEPTH)) u_tape_loader (
		.clk_sys, .reset,
		.model(model_q),
		.cpu_addr, .cpu_rd, .cpu_m1,
		.tape_len, .tape_format, .tb_rdata, .tb_raddr,
		.ld_req, .ld_addr, .ld_data,
		.loading, .patch_hit, .patch_data
	);

	// ========================================================================
	// Main memory
	// ========================================================================
	ram_map u_ram_map (
		.ram_size(ram_size_q),
		.cpu_addr, .cpu_m1,
		.map_addr, .map_hit
	);

	ram_arbiter u_ram_arbiter (
		.clk_sys, .reset, .loading,
		.ld_req, .ld_addr, .ld_data,
		.map_addr, .map_hit,
		.cpu_rd, .cpu_wr, .cpu_wdata,
		.patch_hit, .patch_data,
		.mem_rdata, .mem_addr, .mem_we, .mem_wdata,
		.cpu_rdata, .cpu_rvalid
	);

	main_ram u_main_ram (
		.clk_sys, .mem_addr, .mem_we, .mem_wdata, .mem_rdata
	);

endmodule

`default_nettype wire

//--- zx81_mem_assertions.sv
`default_nettype none

module zx81_mem_assertions (
	input logic                                clk_sys,
	input logic                                reset,
	input logic                                cpu_rd,
	input logic                                cpu_rvalid,
	input logic                                loading,
	input logic                                ld_req,
	input logic                                mem_we,
	input logic [zx81_mem_pkg::RAM_ADDR_W-1:0] mem_addr,
	input logic [zx81_mem_pkg::DATA_W-1:0]     mem_wdata,
	input logic [zx81_mem_pkg::RAM_ADDR_W-1:0] ld_addr,
	input logic [zx81_mem_pkg::DATA_W-1:0]     ld_data
);
	timeunit 1ns;
	timeprecision 1ps;

	// Reply exactly one cycle after the strobe
	rvalid_after_rd: assert property (@(posedge clk_sys) disable iff (reset)
		cpu_rd |=> cpu_rvalid)
		else $error("cpu_rvalid missing one cycle after cpu_rd");

	no_spurious_rvalid: assert property (@(posedge clk_sys) disable iff (reset)
		!cpu_rd |=> !cpu_rvalid)
		else $error("cpu_rvalid high without a read strobe");

	// CPU locked out of RAM for the whole load
	no_cpu_write_loading: assert property (@(posedge clk_sys) disable iff (reset)
		(loading && !ld_req) |-> !mem_we)
		else $error("CPU write granted while loading");

	loader_owns_ram: assert property (@(posedge clk_sys) disable iff (reset)
		ld_req |-> (mem_we && mem_addr == ld_addr && mem_wdata == ld_data))
		else $error("RAM write during ld_req not from the loader");

endmodule

bind ram_arbiter zx81_mem_assertions u_arbiter_assertions (
	.clk_sys(clk_sys),
	.reset(reset),
	.cpu_rd(cpu_rd),
	.cpu_rvalid(cpu_rvalid),
	.loading(loading),
	.ld_req(ld_req),
	.mem_we(mem_we),
	.mem_addr(mem_addr),
	.mem_wdata(mem_wdata),
	.ld_addr(ld_addr),
	.ld_data(ld_data)
);

`default_nettype wire

//--- zx81_mem_tb.sv
`default_nettype none

module zx81_mem_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import zx81_mem_pkg::*;

	localparam int MAX_TAPE    = 256;
	// About 3 cycles per access, two copies of up to MAX_TAPE bytes, wide margin
	localparam int CYCLE_LIMIT = 40000;

	localparam int KIND_EXACT = 0;
	localparam int KIND_FLAG  = 1;
	localparam int KIND_ANY   = 2;

	logic                   clk_sys = 1'b0;
	logic                   reset;
	machine_t               model;
	ram_size_t              ram_size;
	logic                   dl_active;
	logic                   dl_wr;
	logic [TAPE_ADDR_W-1:0] dl_addr;
	logic [DATA_W-1:0]      dl_data;
	logic [7:0]             dl_index;
	logic [CPU_ADDR_W-1:0]  cpu_addr;
	logic [DATA_W-1:0]      cpu_wdata;
	logic                   cpu_rd;
	logic                   cpu_wr;
	logic                   cpu_m1;
	logic [DATA_W-1:0]      cpu_rdata;
	logic                   cpu_rvalid;
	logic                   loading;
	logic                   tape_ready;

	// Reference state
	logic [DATA_W-1:0] ram_model [0:65535];
	bit                known [0:65535];
	logic [DATA_W-1:0] tape_bytes [$];
	machine_t          cur_model;
	ram_size_t         cur_size;
	bit                load_exp;
	bit                copy_done;

	// Outstanding reads, oldest first
	logic [DATA_W-1:0] exp_data [$];
	int                exp_kind [$];
	string             exp_name [$];

	int                replies = 0;
	logic [DATA_W-1:0] last_rdata;
	int                read_errors = 0;
	int                state_errors = 0;
	int                cycles = 0;

	zx81_mem_top #(.TAPE_DEPTH(16384)) UUT (.*);

	always #50 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

	// ========================================================================
	// Reference model
	// ========================================================================
	function automatic logic [16:0] ref_map(input ram_size_t size,
			input logic [CPU_ADDR_W-1:0] a, input logic m1);
		logic                  hit;
		logic [RAM_ADDR_W-1:0] p;
		hit = a[14] || ((size == RAM_32K || size == RAM_48K) && a[15:14] == 2'b10);
		case (size)
			RAM_1K:  p = 16'h4000 + {6'd0, a[9:0]};
			RAM_16K: p = 16'h4000 + {2'd0, a[13:0]};
			RAM_32K: p = (a[15:14] == 2'b10) ? 16'h8000 + {2'd0, a[13:0]} :
				16'h4000 + {2'd0, a[13:0]};
			default: begin
				if (a[15:14] == 2'b10)
					p = 16'h8000 + {2'd0, a[13:0]};
				else if (a[15:14] == 2'b11 && !m1)
					p = 16'hC000 + {2'd0, a[13:0]};
				else
					p = 16'h4000 + {2'd0, a[13:0]};
			end
		endcase
		return {hit, p};
	endfunction

	function automatic logic [DATA_W-1:0] expected_read(input logic [CPU_ADDR_W-1:0] addr,
			input logic m1, output int kind);
		logic [16:0]           map;
		logic [CPU_ADDR_W-1:0] ofs;
		kind = KIND_EXACT;
		ofs  = addr - ((cur_model == MACHINE_ZX81) ? 16'h0347 : 16'h0207);
		if (load_exp) begin
			if (int'(ofs) >= PATCH_LEN)
				return 8'hFF;
			case (ofs[2:0])
				3'd0: return OP_XOR_A;
				3'd1: begin
					if (!copy_done)
						kind = KIND_FLAG;
					return copy_done ? OP_SCF : OP_NOP;
				end
				3'd2: return OP_JR_NC;
				3'd3: return 8'hFD;
				3'd4: return OP_JP;
				3'd5: return (cur_model == MACHINE_ZX81) ? 8'h07 : 8'h03;
				default: return 8'h02;
			endcase
		end
		map = ref_map(cur_size, addr, m1);
		if (!map[16])
			return 8'hFF;
		if (!known[map[15:0]])
			kind = KIND_ANY;
		return ram_model[map[15:0]];
	endfunction

	// ========================================================================
	// Checks
	// ========================================================================
	task automatic check_byte(input string name, input logic [DATA_W-1:0] exp,
			input logic [DATA_W-1:0] act);
		if (act !== exp) begin
			$display("error %s: expected %h, actual %h", name, exp, act);
			read_errors++;
		end
	endtask

	task automatic check_state(input string name, input logic exp_loading,
			input logic exp_ready);
		@(negedge clk_sys);
		if (loading !== exp_loading || tape_ready !== exp_ready) begin
			$display("error %s: expected loading=%b tape_ready=%b, actual loading=%b tape_ready=%b",
				name, exp_loading, exp_ready, loading, tape_ready);
			state_errors++;
		end
	endtask

	// Read replies are compared mid cycle
	always @(negedge clk_sys) begin : reply_check
		logic [DATA_W-1:0] exp;
		int                kind;
		string             name;
		if (cpu_rvalid === 1'b1) begin
			if (exp_data.size() == 0) begin
				$display("cpu_rvalid went high with no read outstanding");
				read_errors++;
			end else begin
				exp  = exp_data.pop_front();
				kind = exp_kind.pop_front();
				name = exp_name.pop_front();
				if (kind == KIND_EXACT)
					check_byte(name, exp, cpu_rdata);
				else if (kind == KIND_FLAG && cpu_rdata !== OP_NOP && cpu_rdata !== OP_SCF) begin
					$display("error %s: expected %h or %h, actual %h", name,
						OP_NOP, OP_SCF, cpu_rdata);
					read_errors++;
				end
			end
			last_rdata = cpu_rdata;
			replies++;
		end
	end

	// ========================================================================
	// Bus tasks
	// ========================================================================
	task automatic apply_reset(input machine_t m, input ram_size_t s);
		@(posedge clk_sys);
		reset    <= 1'b1;
		model    <= m;
		ram_size <= s;
		repeat (2) @(posedge clk_sys);
		reset     <= 1'b0;
		cur_model = m;
		cur_size  = s;
		load_exp  = 1'b0;
		copy_done = 1'b0;
	endtask

	task automatic cpu_write(input logic [CPU_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		logic [16:0] map;
		map = ref_map(cur_size, addr, 1'b0);
		if (map[16] && !load_exp) begin
			ram_model[map[15:0]] = data;
			known[map[15:0]]     = 1'b1;
		end
		@(posedge clk_sys);
		cpu_addr  <= addr;
		cpu_wdata <= data;
		cpu_m1    <= 1'b0;
		cpu_wr    <= 1'b1;
		@(posedge clk_sys);
		cpu_wr <= 1'b0;
	endtask

	task automatic cpu_read(input logic [CPU_ADDR_W-1:0] addr, input logic m1, input string name);
		logic [DATA_W-1:0] exp;
		int                kind;
		int                seen;
		int                waited;
		exp  = expected_read(addr, m1, kind);
		seen = replies;
		exp_data.push_back(exp);
		exp_kind.push_back(kind);
		exp_name.push_back(name);
		@(posedge clk_sys);
		cpu_addr <= addr;
		cpu_m1   <= m1;
		cpu_rd   <= 1'b1;
		@(posedge clk_sys);
		cpu_rd <= 1'b0;
		cpu_m1 <= 1'b0;
		waited = 0;
		while (replies == seen && waited < 4) begin
			@(posedge clk_sys);
			waited++;
		end
		if (replies == seen) begin
			$display("No cpu_rvalid for read %s at address %h", name, addr);
			state_errors++;
			void'(exp_data.pop_front());
			void'(exp_kind.pop_front());
			void'(exp_name.pop_front());
		end
	endtask

	task automatic download(input logic [7:0] index, input int len, input bit keep);
		logic [DATA_W-1:0] b;
		int                i;
		if (keep)
			tape_bytes.delete();
		@(posedge clk_sys);
		dl_index  <= index;
		dl_active <= 1'b1;
		for (i = 0; i < len; i++) begin
			b = 8'($urandom);
			if (keep)
				tape_bytes.push_back(b);
			@(posedge clk_sys);
			dl_wr   <= 1'b1;
			dl_addr <= TAPE_ADDR_W'(i);
			dl_data <= b;
		end
		@(posedge clk_sys);
		dl_wr <= 1'b0;
		@(posedge clk_sys);
		dl_active <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	// Trap, poll the patch until SCF, leave, then read back the copied tape
	task automatic run_load(input string name, input logic [RAM_ADDR_W-1:0] base);
		logic [CPU_ADDR_W-1:0] entry;
		int                    polls;
		int                    i;
		bit                    done;
		entry = (cur_model == MACHINE_ZX81) ? TRAP_ENTRY_ZX81 : TRAP_ENTRY_ZX80;
		cpu_write(16'h6000, 8'h5A);
		cpu_write(base + RAM_ADDR_W'(tape_bytes.size()), 8'hC5);
		load_exp  = 1'b1;
		copy_done = 1'b0;
		cpu_read(entry, 1'b1, {name, " trap fetch"});
		check_state({name, " loading up"}, 1'b1, 1'b1);
		for (i = 0; i < PATCH_LEN; i++)
			cpu_read(entry + CPU_ADDR_W'(i), 1'b1, {name, " patch"});
		cpu_write(16'h6000, 8'hA5);
		cpu_read(16'h6000, 1'b0, {name, " ram locked"});
		polls = 0;
		done  = 1'b0;
		while (!done && polls < MAX_TAPE) begin
			cpu_read(entry + 16'd1, 1'b1, {name, " poll"});
			polls++;
			done = (last_rdata == OP_SCF);
		end
		if (!done) begin
			$display("%s: patch byte 1 never turned to SCF", name);
			state_errors++;
		end
		copy_done = 1'b1;
		for (i = 0; i < PATCH_LEN; i++)
			cpu_read(entry + CPU_ADDR_W'(i), 1'b1, {name, " patch done"});
		cpu_read(16'h0000, 1'b1, {name, " exit fetch"});
		load_exp = 1'b0;
		check_state({name, " loading down"}, 1'b0, 1'b1);
		for (i = 0; i < tape_bytes.size(); i++) begin
			ram_model[base + RAM_ADDR_W'(i)] = tape_bytes[i];
			known[base + RAM_ADDR_W'(i)]     = 1'b1;
		end
		// One past the end holds the marker
		for (i = 0; i <= tape_bytes.size(); i++)
			cpu_read(base + RAM_ADDR_W'(i), 1'b0, {name, " tape data"});
		cpu_read(16'h6000, 1'b0, {name, " blocked write"});
	endtask

	// ========================================================================
	// Stimulus
	// ========================================================================
	initial begin
		int                    i;
		int                    len;
		logic [CPU_ADDR_W-1:0] addr;
		logic [CPU_ADDR_W-1:0] wr_addrs [$];
		void'($urandom(10605));
		reset     <= 1'b1;
		model     <= MACHINE_ZX81;
		ram_size  <= RAM_16K;
		dl_active <= 1'b0;
		dl_wr     <= 1'b0;
		dl_addr   <= '0;
		dl_data   <= '0;
		dl_index  <= '0;
		cpu_addr  <= '0;
		cpu_wdata <= '0;
		cpu_rd    <= 1'b0;
		cpu_wr    <= 1'b0;
		cpu_m1    <= 1'b0;

		// 16K map with mirroring
		apply_reset(MACHINE_ZX81, RAM_16K);
		for (i = 0; i < 48; i++) begin
			addr = 16'h4000 + 16'($urandom % 32'hC000);
			wr_addrs.push_back(addr);
			cpu_write(addr, 8'($urandom));
		end
		for (i = 0; i < wr_addrs.size(); i++) begin
			cpu_read(wr_addrs[i], 1'b0, "16k readback");
			cpu_read({~wr_addrs[i][15], wr_addrs[i][14:0]}, 1'b0, "16k mirror");
		end
		for (i = 0; i < 12; i++)
			cpu_read(16'($urandom % 32'h4000), 1'b0, "16k below 4000h");

		// 48K then 32K upper bank
		apply_reset(MACHINE_ZX81, RAM_48K);
		wr_addrs.delete();
		for (i = 0; i < 24; i++) begin
			addr = 16'hC000 | 16'($urandom % 32'h4000);
			wr_addrs.push_back(addr);
			cpu_write(addr, 8'($urandom));
			cpu_write({2'b01, addr[13:0]}, 8'($urandom));
		end
		for (i = 0; i < wr_addrs.size(); i++) begin
			cpu_read(wr_addrs[i], 1'b0, "48k upper bank");
			cpu_read(wr_addrs[i], 1'b1, "48k m1 mirror");
		end
		apply_reset(MACHINE_ZX81, RAM_32K);
		for (i = 0; i < wr_addrs.size(); i++) begin
			cpu_write({2'b10, wr_addrs[i][13:0]}, 8'($urandom));
			cpu_write(wr_addrs[i], 8'($urandom));
		end
		for (i = 0; i < wr_addrs.size(); i++) begin
			cpu_read(wr_addrs[i], 1'b0, "32k c000h mirror");
			cpu_read(wr_addrs[i], 1'b1, "32k c000h m1 mirror");
			cpu_read({2'b01, wr_addrs[i][13:0]}, 1'b0, "32k 4000h");
			cpu_read({2'b10, wr_addrs[i][13:0]}, 1'b0, "32k 8000h");
		end

		// P download, stray non-tape download, ZX81 load
		apply_reset(MACHINE_ZX81, RAM_16K);
		len = 16 + int'($urandom % 32'd200);
		download(8'h41, len, 1'b1);
		check_state("p download", 1'b0, 1'b1);
		download(8'h21, len + 10, 1'b0);
		check_state("non-tape download", 1'b0, 1'b1);
		run_load("zx81 p load", LOAD_BASE_P);

		// O download, ZX80 load, reset drops the P tape first
		apply_reset(MACHINE_ZX80, RAM_16K);
		check_state("tape after reset", 1'b0, 1'b0);
		len = 16 + int'($urandom % 32'd200);
		download(8'h01, len, 1'b1);
		check_state("o download", 1'b0, 1'b1);
		run_load("zx80 o load", LOAD_BASE_O);

		// 1K mirrors everywhere
		apply_reset(MACHINE_ZX81, RAM_1K);
		wr_addrs.delete();
		for (i = 0; i < 16; i++) begin
			addr = 16'($urandom) | 16'h4000;
			wr_addrs.push_back(addr);
			cpu_write(addr, 8'($urandom));
		end
		for (i = 0; i < wr_addrs.size(); i++) begin
			cpu_read({6'b010000, wr_addrs[i][9:0]}, 1'b0, "1k base");
			cpu_read({2'b11, 4'($urandom), wr_addrs[i][9:0]}, 1'b0, "1k mirror");
		end
		for (i = 0; i < 8; i++)
			cpu_read({2'b10, 14'($urandom)}, 1'b0, "1k 8000h unmapped");

		repeat (4) @(posedge clk_sys);
		$display("Read errors: %0d, state errors: %0d", read_errors, state_errors);
		if (read_errors == 0 && state_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- zx81_mem.f
zx81_mem_pkg.sv
tape_buffer.sv
tape_loader.sv
ram_map.sv
ram_arbiter.sv
main_ram.sv
zx81_mem_top.sv
zx81_mem_assertions.sv
zx81_mem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the zx81_mem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module zx81_mem_tb \
	-f zx81_mem.f \
	-o zx81_mem_sim \
	&& ./obj_dir/zx81_mem_sim 2>&1 | tee /dev/stderr \
	| grep "^Simulation completed successfully$" > /dev/null \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
